// ==== Bender.yml ====
package:
  name: issue_stage

sources:
  - common/issue_pkg.sv
  - issue/operand_fetch.sv
  - issue/hazard_check.sv
  - issue/issue_select.sv
  - issue/dispatch_regs.sv
  - rtl/issue_stage.sv
  - target: test
    files:
      - verif/issue_stage_tb.sv

// ==== common/issue_pkg.sv ====
package issue_pkg;

    // Widths with a meaning of their own
    typedef logic [63:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [63:0] imm_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  mem_width_t;
    typedef logic [11:0] lsp_offset_t;

    // Instruction class, any other encoding is never issued
    typedef enum logic [2:0] {
        OT_INT   = 3'd0,
        OT_LOAD  = 3'd1,
        OT_STORE = 3'd2
    } op_type_e;

    typedef enum logic [1:0] {
        OPR1_RS1  = 2'd0,
        OPR1_PC   = 2'd1,
        OPR1_ZERO = 2'd2,
        OPR1_ZIMM = 2'd3
    } opr1_sel_e;

    typedef enum logic [1:0] {
        OPR2_RS2  = 2'd0,
        OPR2_IMM  = 2'd1,
        OPR2_FOUR = 2'd2
    } opr2_sel_e;

    // One decoded instruction from the decoder
    typedef struct packed {
        xlen_t      pc;
        op_type_e   op_type;
        alu_op_t    op;
        logic       option;
        opr1_sel_e  opr1_sel;
        opr2_sel_e  opr2_sel;
        imm_t       imm;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        logic       wb_en;
        logic       mem_sign;
        mem_width_t mem_width;
    } dec_bundle_t;

    // A bypass source, either in execute, memory or writeback
    typedef struct packed {
        logic     valid;
        logic     wb_en;
        reg_idx_t dst;
        xlen_t    result;
    } result_fwd_t;

    typedef struct packed {
        xlen_t    pc;
        reg_idx_t dst;
        logic     wb_en;
        alu_op_t  op;
        logic     option;
        xlen_t    operand1;
        xlen_t    operand2;
    } int_issue_t;

    typedef struct packed {
        xlen_t       pc;
        reg_idx_t    dst;
        logic        wb_en;
        xlen_t       base;
        lsp_offset_t offset;
        xlen_t       source;
        logic        mem_sign;
        mem_width_t  mem_width;
    } lsp_issue_t;

    typedef struct packed {
        xlen_t operand1;
        xlen_t operand2;
        logic  ready1;
        logic  ready2;
    } slot_operands_t;

endpackage

// ==== files.f ====
common/issue_pkg.sv
issue/operand_fetch.sv
issue/hazard_check.sv
issue/issue_select.sv
issue/dispatch_regs.sv
rtl/issue_stage.sv
verif/issue_stage_tb.sv

// ==== issue/dispatch_regs.sv ====
`timescale 1ns/100ps

module dispatch_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_ip0,
    input  logic                      issue_ip1,
    input  logic                      issue_lsp,
    input  logic                      lsp_from_dec1,
    input  logic                      flush,
    input  issue_pkg::dec_bundle_t    dec0,
    input  issue_pkg::dec_bundle_t    dec1,
    input  issue_pkg::slot_operands_t opr0,
    input  issue_pkg::slot_operands_t opr1,
    input  logic                      ip0_ready,
    input  logic                      ip1_ready,
    input  logic                      lsp_ready,
    output issue_pkg::int_issue_t     ip0_issue,
    output issue_pkg::int_issue_t     ip1_issue,
    output logic                      ip0_valid,
    output logic                      ip1_valid,
    output issue_pkg::lsp_issue_t     lsp_issue,
    output logic                      lsp_valid
);

    function automatic issue_pkg::int_issue_t to_int(input issue_pkg::dec_bundle_t d,
                                                     input issue_pkg::slot_operands_t o);
        issue_pkg::int_issue_t r;
        r.pc       = d.pc;
        r.dst      = d.rd;
        r.wb_en    = d.wb_en;
        r.op       = d.op;
        r.option   = d.option;
        r.operand1 = o.operand1;
        r.operand2 = o.operand2;
        return r;
    endfunction

    // Address base from operand 1, store data from operand 2
    function automatic issue_pkg::lsp_issue_t to_lsp(input issue_pkg::dec_bundle_t d,
                                                     input issue_pkg::slot_operands_t o);
        issue_pkg::lsp_issue_t r;
        r.pc        = d.pc;
        r.dst       = d.rd;
        r.wb_en     = d.wb_en;
        r.base      = o.operand1;
        r.offset    = d.imm[11:0];
        r.source    = o.operand2;
        r.mem_sign  = d.mem_sign;
        r.mem_width = d.mem_width;
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (issue_ip0)
            ip0_issue <= to_int(dec0, opr0);
        if (issue_ip1)
            ip1_issue <= to_int(dec1, opr1);
        if (issue_lsp)
            lsp_issue <= lsp_from_dec1 ? to_lsp(dec1, opr1) : to_lsp(dec0, opr0);
    end

    // Valid holds until the pipe takes it
    always_ff @(posedge clk) begin
        if (rst) begin
            ip0_valid <= 1'b0;
            ip1_valid <= 1'b0;
            lsp_valid <= 1'b0;
        end else begin
            if (issue_ip0)
                ip0_valid <= 1'b1;
            else if (ip0_ready || flush)
                ip0_valid <= 1'b0;
            if (issue_ip1)
                ip1_valid <= 1'b1;
            else if (ip1_ready || flush)
                ip1_valid <= 1'b0;
            if (issue_lsp)
                lsp_valid <= 1'b1;
            else if (lsp_ready || flush)
                lsp_valid <= 1'b0;
        end
    end

endmodule

// ==== issue/hazard_check.sv ====
`timescale 1ns/100ps

module hazard_check (
    input  issue_pkg::dec_bundle_t dec0,
    input  issue_pkg::dec_bundle_t dec1,
    input  logic                   dec0_valid,
    input  logic                   dec1_valid,
    input  issue_pkg::result_fwd_t ip0_ex,
    input  issue_pkg::result_fwd_t ip1_ex,
    input  issue_pkg::result_fwd_t ip0_wb,
    input  issue_pkg::result_fwd_t ip1_wb,
    input  issue_pkg::result_fwd_t lsp_mem,
    input  logic                   lsp_pending,
    input  issue_pkg::reg_idx_t    lsp_pending_dst,
    output logic [1:0]             waw_ok_int,
    output logic [1:0]             waw_ok_lsp,
    output logic                   pair_ok
);

    issue_pkg::dec_bundle_t dec [2];
    logic                   dec1_reads_rd;

    function automatic logic busy(input issue_pkg::result_fwd_t f,
                                  input issue_pkg::reg_idx_t rd);
        return f.valid && f.wb_en && (f.dst == rd);
    endfunction

    assign dec[0] = dec0;
    assign dec[1] = dec1;

    // Results from different pipes can land out of order
    for (genvar s = 0; s < 2; s++) begin : g_slot
        logic lsp_dst_hit;
        logic int_dst_hit;

        assign lsp_dst_hit = (lsp_mem.wb_en && (lsp_mem.dst == dec[s].rd)) ||
                             (lsp_pending && (lsp_pending_dst == dec[s].rd));
        assign int_dst_hit = busy(ip0_ex, dec[s].rd) || busy(ip1_ex, dec[s].rd) ||
                             busy(ip0_wb, dec[s].rd) || busy(ip1_wb, dec[s].rd);

        assign waw_ok_int[s] = !dec[s].wb_en || !lsp_dst_hit;
        assign waw_ok_lsp[s] = !dec[s].wb_en || !int_dst_hit;
    end

    // RAW from slot 0 into slot 1
    assign dec1_reads_rd =
        ((dec0.rd == dec1.rs1) && (dec1.opr1_sel == issue_pkg::OPR1_RS1)) ||
        ((dec0.rd == dec1.rs2) && (dec1.opr2_sel == issue_pkg::OPR2_RS2));

    assign pair_ok = dec0_valid && dec1_valid &&
                     !(dec0.wb_en && dec1.wb_en && (dec0.rd == dec1.rd)) &&
                     !(dec0.wb_en && dec1_reads_rd);

endmodule

// ==== issue/issue_select.sv ====
`timescale 1ns/100ps

module issue_select (
    input  issue_pkg::dec_bundle_t    dec0,
    input  issue_pkg::dec_bundle_t    dec1,
    input  logic                      dec0_valid,
    input  logic                      dec1_valid,
    input  logic                      flush,
    input  issue_pkg::slot_operands_t opr0,
    input  issue_pkg::slot_operands_t opr1,
    input  logic [1:0]                waw_ok_int,
    input  logic [1:0]                waw_ok_lsp,
    input  logic                      pair_ok,
    input  logic                      ip0_ready,
    input  logic                      ip1_ready,
    input  logic                      lsp_ready,
    output logic                      dec0_ready,
    output logic                      dec1_ready,
    output logic                      issue_ip0,
    output logic                      issue_ip1,
    output logic                      issue_lsp,
    output logic                      lsp_from_dec1
);

    logic dec0_int;
    logic dec0_ls;
    logic dec1_int;
    logic dec1_ls;
    logic dec0_go;
    logic dec1_go;
    logic lsp_from_dec0;
    logic dec0_issued;
    logic dec1_issued;

    assign dec0_int = (dec0.op_type == issue_pkg::OT_INT);
    assign dec0_ls  = (dec0.op_type == issue_pkg::OT_LOAD) ||
                      (dec0.op_type == issue_pkg::OT_STORE);
    assign dec1_int = (dec1.op_type == issue_pkg::OT_INT);
    assign dec1_ls  = (dec1.op_type == issue_pkg::OT_LOAD) ||
                      (dec1.op_type == issue_pkg::OT_STORE);

    // Slot 0 candidates
    assign dec0_go       = !flush && dec0_valid && opr0.ready1 && opr0.ready2;
    assign issue_ip0     = dec0_go && dec0_int && waw_ok_int[0] && ip0_ready;
    assign lsp_from_dec0 = dec0_go && dec0_ls && waw_ok_lsp[0] && lsp_ready;
    assign dec0_issued   = issue_ip0 || lsp_from_dec0;

    // Slot 1 only rides along with slot 0, never alone
    assign dec1_go       = dec0_issued && pair_ok && opr1.ready1 && opr1.ready2;
    assign issue_ip1     = dec1_go && dec1_int && waw_ok_int[1] && ip1_ready;
    assign lsp_from_dec1 = dec1_go && dec1_ls && !dec0_ls && waw_ok_lsp[1] && lsp_ready;
    assign dec1_issued   = issue_ip1 || lsp_from_dec1;

    assign issue_lsp = lsp_from_dec0 || lsp_from_dec1;

    // On flush the decoder side is drained
    assign dec0_ready = !(dec0_valid && !dec0_issued && !flush);
    assign dec1_ready = dec1_valid && dec1_issued;

endmodule

// ==== issue/operand_fetch.sv ====
`timescale 1ns/100ps

module operand_fetch #(
    parameter bit MEM_FORWARD = 1'b1
) (
    input  issue_pkg::dec_bundle_t    slot,
    input  issue_pkg::xlen_t          rs1_data,
    input  issue_pkg::xlen_t          rs2_data,
    input  issue_pkg::result_fwd_t    ip0_ex,
    input  issue_pkg::result_fwd_t    ip1_ex,
    input  issue_pkg::result_fwd_t    ip0_wb,
    input  issue_pkg::result_fwd_t    ip1_wb,
    input  issue_pkg::result_fwd_t    lsp_wb,
    input  issue_pkg::result_fwd_t    lsp_mem,
    input  logic                      ip0_held,
    input  logic                      lsp_pending,
    input  issue_pkg::reg_idx_t       lsp_pending_dst,
    output issue_pkg::slot_operands_t operands
);

    issue_pkg::reg_idx_t src_idx [2];
    issue_pkg::xlen_t    src_data [2];

    function automatic logic hit(input issue_pkg::result_fwd_t f,
                                 input issue_pkg::reg_idx_t idx);
        return f.valid && f.wb_en && (f.dst == idx);
    endfunction

    assign src_idx[0]  = slot.rs1;
    assign src_idx[1]  = slot.rs2;
    assign src_data[0] = rs1_data;
    assign src_data[1] = rs2_data;

    // Later checks override earlier ones, so the order is the priority
    for (genvar i = 0; i < 2; i++) begin : g_src
        logic             rdy;
        issue_pkg::xlen_t val;

        always_comb begin
            rdy = 1'b1;
            val = src_data[i];
            if (hit(ip0_wb, src_idx[i]))
                val = ip0_wb.result;
            if (hit(ip1_wb, src_idx[i]))
                val = ip1_wb.result;
            if (hit(lsp_wb, src_idx[i]))
                val = lsp_wb.result;
            if (hit(ip0_ex, src_idx[i]))
                val = ip0_ex.result;
            if (hit(ip1_ex, src_idx[i]))
                val = ip1_ex.result;
            // Pipe 0 has not taken its dispatch yet, no result exists
            if (ip0_held && ip0_ex.wb_en && (ip0_ex.dst == src_idx[i]))
                rdy = 1'b0;
            // Load in memory stage, data only usable once it returns
            if (lsp_mem.wb_en && (lsp_mem.dst == src_idx[i])) begin
                rdy = 1'b0;
                if (MEM_FORWARD && lsp_mem.valid) begin
                    rdy = 1'b1;
                    val = lsp_mem.result;
                end
            end
            if (lsp_pending && (lsp_pending_dst == src_idx[i]))
                rdy = 1'b0;
            // x0 wins even over a bypass that targets it
            if (src_idx[i] == '0) begin
                rdy = 1'b1;
                val = '0;
            end
        end
    end

    always_comb begin
        operands.ready1 = (slot.opr1_sel == issue_pkg::OPR1_RS1) ? g_src[0].rdy : 1'b1;
        operands.ready2 = (slot.opr2_sel == issue_pkg::OPR2_RS2) ? g_src[1].rdy : 1'b1;
        case (slot.opr1_sel)
            issue_pkg::OPR1_RS1:  operands.operand1 = g_src[0].val;
            issue_pkg::OPR1_PC:   operands.operand1 = slot.pc;
            issue_pkg::OPR1_ZIMM: operands.operand1 = {59'd0, slot.rs1};
            default:              operands.operand1 = '0;
        endcase
        case (slot.opr2_sel)
            issue_pkg::OPR2_RS2:  operands.operand2 = g_src[1].val;
            issue_pkg::OPR2_IMM:  operands.operand2 = slot.imm;
            default:              operands.operand2 = 64'd4;
        endcase
    end

endmodule

// ==== rtl/issue_stage.sv ====
`timescale 1ns/100ps

module issue_stage #(
    parameter bit MEM_FORWARD = 1'b1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  issue_pkg::dec_bundle_t dec0_bundle,
    input  logic                   dec0_valid,
    output logic                   dec0_ready,
    input  issue_pkg::dec_bundle_t dec1_bundle,
    input  logic                   dec1_valid,
    output logic                   dec1_ready,
    output issue_pkg::reg_idx_t    rf_addr [0:3],
    input  issue_pkg::xlen_t       rf_data [0:3],
    output issue_pkg::int_issue_t  ip0_issue,
    output logic                   ip0_valid,
    input  logic                   ip0_ready,
    input  issue_pkg::xlen_t       ip0_fwd,
    output issue_pkg::int_issue_t  ip1_issue,
    output logic                   ip1_valid,
    input  logic                   ip1_ready,
    input  issue_pkg::xlen_t       ip1_fwd,
    output issue_pkg::lsp_issue_t  lsp_issue,
    output logic                   lsp_valid,
    input  logic                   lsp_ready,
    input  issue_pkg::result_fwd_t ip0_wb,
    input  issue_pkg::result_fwd_t ip1_wb,
    input  issue_pkg::result_fwd_t lsp_wb,
    input  issue_pkg::result_fwd_t lsp_mem
);

    issue_pkg::result_fwd_t    ip0_ex;
    issue_pkg::result_fwd_t    ip1_ex;
    issue_pkg::slot_operands_t opr0;
    issue_pkg::slot_operands_t opr1;
    logic                      ip0_held;
    logic                      lsp_pending;
    logic [1:0]                waw_ok_int;
    logic [1:0]                waw_ok_lsp;
    logic                      pair_ok;
    logic                      sel_dec0_ready;
    logic                      sel_dec1_ready;
    logic                      issue_ip0;
    logic                      issue_ip1;
    logic                      issue_lsp;
    logic                      lsp_from_dec1;

    assign rf_addr[0] = dec0_bundle.rs1;
    assign rf_addr[1] = dec0_bundle.rs2;
    assign rf_addr[2] = dec1_bundle.rs1;
    assign rf_addr[3] = dec1_bundle.rs2;

    // Pipe 0 stays visible while held so its destination stalls readers
    assign ip0_ex      = '{valid: ip0_valid, wb_en: ip0_issue.wb_en,
                           dst: ip0_issue.dst, result: ip0_fwd};
    assign ip1_ex      = '{valid: ip1_valid && ip1_ready, wb_en: ip1_issue.wb_en,
                           dst: ip1_issue.dst, result: ip1_fwd};
    assign ip0_held    = ip0_valid && !ip0_ready;
    assign lsp_pending = lsp_valid && lsp_issue.wb_en;

    assign dec0_ready = sel_dec0_ready && !rst;
    assign dec1_ready = sel_dec1_ready && !rst;

    operand_fetch #(.MEM_FORWARD(MEM_FORWARD)) operand_fetch_0 (
        .slot(dec0_bundle), .rs1_data(rf_data[0]), .rs2_data(rf_data[1]),
        .ip0_ex(ip0_ex), .ip1_ex(ip1_ex), .ip0_wb(ip0_wb), .ip1_wb(ip1_wb),
        .lsp_wb(lsp_wb), .lsp_mem(lsp_mem), .ip0_held(ip0_held),
        .lsp_pending(lsp_pending), .lsp_pending_dst(lsp_issue.dst), .operands(opr0)
    );

    operand_fetch #(.MEM_FORWARD(MEM_FORWARD)) operand_fetch_1 (
        .slot(dec1_bundle), .rs1_data(rf_data[2]), .rs2_data(rf_data[3]),
        .ip0_ex(ip0_ex), .ip1_ex(ip1_ex), .ip0_wb(ip0_wb), .ip1_wb(ip1_wb),
        .lsp_wb(lsp_wb), .lsp_mem(lsp_mem), .ip0_held(ip0_held),
        .lsp_pending(lsp_pending), .lsp_pending_dst(lsp_issue.dst), .operands(opr1)
    );

    hazard_check hazard_check_inst (
        .dec0(dec0_bundle), .dec1(dec1_bundle), .dec0_valid(dec0_valid),
        .dec1_valid(dec1_valid), .ip0_ex(ip0_ex), .ip1_ex(ip1_ex), .ip0_wb(ip0_wb),
        .ip1_wb(ip1_wb), .lsp_mem(lsp_mem), .lsp_pending(lsp_pending),
        .lsp_pending_dst(lsp_issue.dst), .waw_ok_int(waw_ok_int),
        .waw_ok_lsp(waw_ok_lsp), .pair_ok(pair_ok)
    );

    issue_select issue_select_inst (
        .dec0(dec0_bundle), .dec1(dec1_bundle), .dec0_valid(dec0_valid),
        .dec1_valid(dec1_valid), .flush(flush), .opr0(opr0), .opr1(opr1),
        .waw_ok_int(waw_ok_int), .waw_ok_lsp(waw_ok_lsp), .pair_ok(pair_ok),
        .ip0_ready(ip0_ready), .ip1_ready(ip1_ready), .lsp_ready(lsp_ready),
        .dec0_ready(sel_dec0_ready), .dec1_ready(sel_dec1_ready),
        .issue_ip0(issue_ip0), .issue_ip1(issue_ip1), .issue_lsp(issue_lsp),
        .lsp_from_dec1(lsp_from_dec1)
    );

    dispatch_regs dispatch_regs_inst (
        .clk(clk), .rst(rst), .issue_ip0(issue_ip0), .issue_ip1(issue_ip1),
        .issue_lsp(issue_lsp), .lsp_from_dec1(lsp_from_dec1), .flush(flush),
        .dec0(dec0_bundle), .dec1(dec1_bundle), .opr0(opr0), .opr1(opr1),
        .ip0_ready(ip0_ready), .ip1_ready(ip1_ready), .lsp_ready(lsp_ready),
        .ip0_issue(ip0_issue), .ip1_issue(ip1_issue), .ip0_valid(ip0_valid),
        .ip1_valid(ip1_valid), .lsp_issue(lsp_issue), .lsp_valid(lsp_valid)
    );

endmodule

// ==== verif/issue_stage_tb.sv ====
`timescale 1ns/100ps

module issue_stage_tb;

    localparam int MAX_CYCLES = 200;

    logic                     clk;
    logic                     rst;
    logic                     flush;
    issue_pkg::dec_bundle_t   dec0_bundle;
    logic                     dec0_valid;
    logic                     dec0_ready;
    issue_pkg::dec_bundle_t   dec1_bundle;
    logic                     dec1_valid;
    logic                     dec1_ready;
    issue_pkg::reg_idx_t      rf_addr [0:3];
    issue_pkg::xlen_t         rf_data [0:3];
    issue_pkg::int_issue_t    ip0_issue;
    logic                     ip0_valid;
    logic                     ip0_ready;
    issue_pkg::xlen_t         ip0_fwd;
    issue_pkg::int_issue_t    ip1_issue;
    logic                     ip1_valid;
    logic                     ip1_ready;
    issue_pkg::xlen_t         ip1_fwd;
    issue_pkg::lsp_issue_t    lsp_issue;
    logic                     lsp_valid;
    logic                     lsp_ready;
    issue_pkg::result_fwd_t   ip0_wb;
    issue_pkg::result_fwd_t   ip1_wb;
    issue_pkg::result_fwd_t   lsp_wb;
    issue_pkg::result_fwd_t   lsp_mem;

    // Register file model and the expected dispatch registers
    issue_pkg::xlen_t         reg_model [0:31];
    logic                     m_ip0_valid;
    logic                     m_ip1_valid;
    logic                     m_lsp_valid;
    issue_pkg::int_issue_t    m_ip0;
    issue_pkg::int_issue_t    m_ip1;
    issue_pkg::lsp_issue_t    m_lsp;

    issue_stage #(.MEM_FORWARD(1'b1)) issue_stage_inst (
        .clk(clk), .rst(rst), .flush(flush),
        .dec0_bundle(dec0_bundle), .dec0_valid(dec0_valid), .dec0_ready(dec0_ready),
        .dec1_bundle(dec1_bundle), .dec1_valid(dec1_valid), .dec1_ready(dec1_ready),
        .rf_addr(rf_addr), .rf_data(rf_data),
        .ip0_issue(ip0_issue), .ip0_valid(ip0_valid), .ip0_ready(ip0_ready), .ip0_fwd(ip0_fwd),
        .ip1_issue(ip1_issue), .ip1_valid(ip1_valid), .ip1_ready(ip1_ready), .ip1_fwd(ip1_fwd),
        .lsp_issue(lsp_issue), .lsp_valid(lsp_valid), .lsp_ready(lsp_ready),
        .ip0_wb(ip0_wb), .ip1_wb(ip1_wb), .lsp_wb(lsp_wb), .lsp_mem(lsp_mem)
    );

    assign rf_data[0] = reg_model[rf_addr[0]];
    assign rf_data[1] = reg_model[rf_addr[1]];
    assign rf_data[2] = reg_model[rf_addr[2]];
    assign rf_data[3] = reg_model[rf_addr[3]];

    always #10 clk = ~clk;

    // Pipe results change every cycle
    always begin
        @(posedge clk);
        #2;
        ip0_fwd = {$urandom, $urandom};
        ip1_fwd = {$urandom, $urandom};
    end

    task automatic fail_now(input string msg);
        $display("error at %0t: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "mismatch");
    endtask

    task automatic check_bit(input logic act, input logic exp, input string what);
        if (act !== exp)
            fail_now($sformatf("%s is %b, expected %b", what, act, exp));
    endtask

    task automatic check_int(input issue_pkg::int_issue_t act,
                             input issue_pkg::int_issue_t exp, input string what);
        if (act !== exp)
            fail_now($sformatf("%s is %h, expected %h", what, act, exp));
    endtask

    task automatic check_lsp(input issue_pkg::lsp_issue_t act,
                             input issue_pkg::lsp_issue_t exp, input string what);
        if (act !== exp)
            fail_now($sformatf("%s is %h, expected %h", what, act, exp));
    endtask

    function automatic logic fwd_hit(input issue_pkg::result_fwd_t f,
                                     input issue_pkg::reg_idx_t idx);
        return f.valid && f.wb_en && (f.dst == idx);
    endfunction

    // Value of one source register with the lowest priority checked first
    function automatic issue_pkg::xlen_t ref_src(input issue_pkg::reg_idx_t idx);
        issue_pkg::xlen_t v;
        v = reg_model[idx];
        if (fwd_hit(ip0_wb, idx))
            v = ip0_wb.result;
        if (fwd_hit(ip1_wb, idx))
            v = ip1_wb.result;
        if (fwd_hit(lsp_wb, idx))
            v = lsp_wb.result;
        if (m_ip0_valid && m_ip0.wb_en && m_ip0.dst == idx)
            v = ip0_fwd;
        if (m_ip1_valid && ip1_ready && m_ip1.wb_en && m_ip1.dst == idx)
            v = ip1_fwd;
        if (fwd_hit(lsp_mem, idx))
            v = lsp_mem.result;
        if (idx == 5'd0)
            v = '0;
        return v;
    endfunction

    function automatic issue_pkg::xlen_t ref_opr1(input issue_pkg::dec_bundle_t d);
        case (d.opr1_sel)
            issue_pkg::OPR1_RS1:  return ref_src(d.rs1);
            issue_pkg::OPR1_PC:   return d.pc;
            issue_pkg::OPR1_ZIMM: return {59'd0, d.rs1};
            default:              return '0;
        endcase
    endfunction

    function automatic issue_pkg::xlen_t ref_opr2(input issue_pkg::dec_bundle_t d);
        case (d.opr2_sel)
            issue_pkg::OPR2_RS2: return ref_src(d.rs2);
            issue_pkg::OPR2_IMM: return d.imm;
            default:             return 64'd4;
        endcase
    endfunction

    function automatic issue_pkg::int_issue_t expect_int(input issue_pkg::dec_bundle_t d);
        issue_pkg::int_issue_t r;
        r = '{pc: d.pc, dst: d.rd, wb_en: d.wb_en, op: d.op, option: d.option,
              operand1: ref_opr1(d), operand2: ref_opr2(d)};
        return r;
    endfunction

    function automatic issue_pkg::lsp_issue_t expect_lsp(input issue_pkg::dec_bundle_t d);
        issue_pkg::lsp_issue_t r;
        r = '{pc: d.pc, dst: d.rd, wb_en: d.wb_en, base: ref_opr1(d), offset: d.imm[11:0],
              source: ref_opr2(d), mem_sign: d.mem_sign, mem_width: d.mem_width};
        return r;
    endfunction

    function automatic logic is_mem(input issue_pkg::dec_bundle_t d);
        return d.op_type == issue_pkg::OT_LOAD || d.op_type == issue_pkg::OT_STORE;
    endfunction

    // Compare at the falling edge, where every input and output is settled
    always @(negedge clk) begin : compare
        logic                  acc0;
        logic                  acc1;
        issue_pkg::int_issue_t e_ip0;
        issue_pkg::int_issue_t e_ip1;
        if (rst) begin
            m_ip0_valid = 1'b0;
            m_ip1_valid = 1'b0;
            m_lsp_valid = 1'b0;
        end else begin
            check_bit(ip0_valid, m_ip0_valid, "ip0_valid");
            check_bit(ip1_valid, m_ip1_valid, "ip1_valid");
            check_bit(lsp_valid, m_lsp_valid, "lsp_valid");
            if (m_ip0_valid)
                check_int(ip0_issue, m_ip0, "ip0_issue");
            if (m_ip1_valid)
                check_int(ip1_issue, m_ip1, "ip1_issue");
            if (m_lsp_valid)
                check_lsp(lsp_issue, m_lsp, "lsp_issue");
            acc0 = dec0_valid && dec0_ready && !flush;
            acc1 = dec1_valid && dec1_ready && !flush;
            // Expected dispatches see the dispatch state from before this edge
            e_ip0 = expect_int(dec0_bundle);
            e_ip1 = expect_int(dec1_bundle);
            if (acc0 && is_mem(dec0_bundle))
                m_lsp = expect_lsp(dec0_bundle);
            else if (acc1 && is_mem(dec1_bundle))
                m_lsp = expect_lsp(dec1_bundle);
            if (acc0 && dec0_bundle.op_type == issue_pkg::OT_INT)
                m_ip0 = e_ip0;
            if (acc1 && dec1_bundle.op_type == issue_pkg::OT_INT)
                m_ip1 = e_ip1;
            if (acc0 && dec0_bundle.op_type == issue_pkg::OT_INT)
                m_ip0_valid = 1'b1;
            else if (ip0_ready || flush)
                m_ip0_valid = 1'b0;
            if (acc1 && dec1_bundle.op_type == issue_pkg::OT_INT)
                m_ip1_valid = 1'b1;
            else if (ip1_ready || flush)
                m_ip1_valid = 1'b0;
            if ((acc0 && is_mem(dec0_bundle)) || (acc1 && is_mem(dec1_bundle)))
                m_lsp_valid = 1'b1;
            else if (lsp_ready || flush)
                m_lsp_valid = 1'b0;
        end
    end

    initial begin
        #(MAX_CYCLES * 40);
        $display("Run did not finish within %0d cycles", MAX_CYCLES * 2);
        $display("Errors found");
        $fatal(1, "timeout");
    end

    function automatic issue_pkg::dec_bundle_t mk_int(input issue_pkg::reg_idx_t rs1,
                                                      input issue_pkg::reg_idx_t rs2,
                                                      input issue_pkg::reg_idx_t rd);
        issue_pkg::dec_bundle_t b;
        b = '0;
        b.pc       = {$urandom, $urandom};
        b.op_type  = issue_pkg::OT_INT;
        b.op       = issue_pkg::alu_op_t'($urandom);
        b.option   = $urandom;
        b.opr1_sel = issue_pkg::OPR1_RS1;
        b.opr2_sel = issue_pkg::OPR2_RS2;
        b.imm      = {$urandom, $urandom};
        b.rs1      = rs1;
        b.rs2      = rs2;
        b.rd       = rd;
        b.wb_en    = 1'b1;
        return b;
    endfunction

    function automatic issue_pkg::dec_bundle_t mk_mem(input logic load,
                                                      input issue_pkg::reg_idx_t rs1,
                                                      input issue_pkg::reg_idx_t rs2,
                                                      input issue_pkg::reg_idx_t rd);
        issue_pkg::dec_bundle_t b;
        b = mk_int(rs1, rs2, rd);
        b.op_type   = load ? issue_pkg::OT_LOAD : issue_pkg::OT_STORE;
        b.wb_en     = load;
        b.mem_sign  = $urandom;
        b.mem_width = issue_pkg::mem_width_t'($urandom);
        return b;
    endfunction

    // Holds the pair until slot 0 is taken
    // Called 2 ns after a rising edge
    task automatic send(input issue_pkg::dec_bundle_t b0, input logic v1,
                        input issue_pkg::dec_bundle_t b1, output logic got1);
        dec0_bundle = b0;
        dec0_valid  = 1'b1;
        dec1_bundle = b1;
        dec1_valid  = v1;
        do
            @(negedge clk);
        while (!dec0_ready);
        got1 = v1 && dec1_ready;
        @(posedge clk);
        #2;
        dec0_valid = 1'b0;
        dec1_valid = 1'b0;
    endtask

    // A slot 1 left behind moves up to slot 0 as the decoder does
    task automatic send_pair(input issue_pkg::dec_bundle_t b0,
                             input issue_pkg::dec_bundle_t b1, input logic exp_got1);
        logic got1;
        send(b0, 1'b1, b1, got1);
        check_bit(got1, exp_got1, "dec1 accepted with dec0");
        if (!got1)
            send(b1, 1'b0, b1, got1);
    endtask

    task automatic send_one(input issue_pkg::dec_bundle_t b0);
        logic got1;
        send(b0, 1'b0, b0, got1);
    endtask

    task automatic expect_stall(input issue_pkg::dec_bundle_t b0, input int cycles);
        dec0_bundle = b0;
        dec0_valid  = 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            check_bit(dec0_ready, 1'b0, "dec0_ready during stall");
        end
        @(posedge clk);
        #2;
    endtask

    initial begin : stimulus
        issue_pkg::dec_bundle_t b;
        void'($urandom(78438));
        clk = 1'b0;
        rst = 1'b1;
        flush = 1'b0;
        dec0_bundle = '0;
        dec1_bundle = '0;
        dec0_valid = 1'b0;
        dec1_valid = 1'b0;
        ip0_ready = 1'b1;
        ip1_ready = 1'b1;
        lsp_ready = 1'b1;
        ip0_fwd = '0;
        ip1_fwd = '0;
        ip0_wb = '0;
        ip1_wb = '0;
        lsp_wb = '0;
        lsp_mem = '0;
        for (int i = 0; i < 32; i++)
            reg_model[i] = (i == 0) ? '0 : {$urandom, $urandom};
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_bit(dec0_ready, 1'b0, "dec0_ready in reset");
        check_bit(dec1_ready, 1'b0, "dec1_ready in reset");
        check_bit(ip0_valid | ip1_valid | lsp_valid, 1'b0, "valid in reset");
        @(posedge clk);
        #2;
        rst = 1'b0;

        // Single instruction, then other operand selects, then x0
        send_one(mk_int(5'd3, 5'd4, 5'd20));
        b = mk_int(5'd6, 5'd0, 5'd21);
        b.opr1_sel = issue_pkg::OPR1_ZIMM;
        b.opr2_sel = issue_pkg::OPR2_FOUR;
        send_one(b);
        b.opr1_sel = issue_pkg::OPR1_PC;
        b.opr2_sel = issue_pkg::OPR2_IMM;
        send_one(b);
        ip0_wb = '{valid: 1'b1, wb_en: 1'b1, dst: 5'd0, result: {$urandom, $urandom}};
        send_one(mk_int(5'd0, 5'd0, 5'd22));
        ip0_wb = '0;

        // Execute beats writeback, writeback beats the register file
        send_one(mk_int(5'd1, 5'd2, 5'd7));
        ip0_wb = '{valid: 1'b1, wb_en: 1'b1, dst: 5'd7, result: {$urandom, $urandom}};
        lsp_wb = '{valid: 1'b1, wb_en: 1'b1, dst: 5'd7, result: {$urandom, $urandom}};
        send_one(mk_int(5'd7, 5'd7, 5'd8));
        send_one(mk_int(5'd7, 5'd3, 5'd9));
        ip0_wb = '0;
        lsp_wb = '0;

        // Load in the memory stage
        lsp_mem = '{valid: 1'b0, wb_en: 1'b1, dst: 5'd9, result: {$urandom, $urandom}};
        b = mk_int(5'd9, 5'd2, 5'd10);
        expect_stall(b, 2);
        lsp_mem.valid = 1'b1;
        send_one(b);
        lsp_mem = '0;

        // Independent and dependent pairs
        send_pair(mk_int(5'd1, 5'd2, 5'd11), mk_int(5'd3, 5'd4, 5'd12), 1'b1);
        send_pair(mk_int(5'd1, 5'd2, 5'd11), mk_int(5'd11, 5'd4, 5'd13), 1'b0);
        send_pair(mk_int(5'd1, 5'd2, 5'd12), mk_int(5'd3, 5'd4, 5'd12), 1'b0);

        // Loads and stores in either slot
        send_one(mk_mem(1'b1, 5'd5, 5'd6, 5'd18));
        send_pair(mk_int(5'd1, 5'd2, 5'd17), mk_mem(1'b0, 5'd3, 5'd4, 5'd0), 1'b1);
        send_pair(mk_mem(1'b1, 5'd7, 5'd8, 5'd19), mk_mem(1'b0, 5'd5, 5'd6, 5'd0), 1'b0);

        // Back-pressure on pipe 0 stalls a reader of its destination
        send_one(mk_int(5'd1, 5'd2, 5'd14));
        ip0_ready = 1'b0;
        b = mk_mem(1'b1, 5'd14, 5'd3, 5'd15);
        expect_stall(b, 3);
        ip0_ready = 1'b1;
        send_one(b);

        // Flush drops held dispatches
        send_pair(mk_int(5'd1, 5'd2, 5'd23), mk_int(5'd3, 5'd4, 5'd24), 1'b1);
        ip0_ready = 1'b0;
        ip1_ready = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        @(negedge clk);
        check_bit(ip0_valid | ip1_valid | lsp_valid, 1'b0, "valid after flush");
        @(posedge clk);
        #2;
        ip0_ready = 1'b1;
        ip1_ready = 1'b1;
        repeat (3) @(posedge clk);

        $display("No errors");
        $finish;
    end

endmodule
